/* Bender.yml */
package:
  name: execute_pipe

sources:
  - hw/ExecPkg.sv
  - hw/Alu.sv
  - hw/AluDecode.sv
  - hw/AluStage.sv
  - hw/BranchResolve.sv
  - hw/ExecutePipe.sv
  - target: test
    files:
      - tests/ExecutePipe_assertions.sv
      - tests/ExecutePipeTb.sv

/* compile.f */
hw/ExecPkg.sv
hw/Alu.sv
hw/AluDecode.sv
hw/AluStage.sv
hw/BranchResolve.sv
hw/ExecutePipe.sv
tests/ExecutePipe_assertions.sv
tests/ExecutePipeTb.sv

/* hw/Alu.sv */
`timescale 1ns/1ps

module Alu import ExecPkg::*; (
    input  aluOp_t operation,
    input  word_t  inX,
    input  word_t  inY,
    output word_t  result,
    output logic   zero
);

    logic signed [31:0] signedX;
    logic signed [31:0] signedY;
    logic        [4:0]  shamt;

    assign signedX = $signed(inX);
    assign signedY = $signed(inY);
    assign shamt   = inY[4:0]; // Only low five bits shift

    assign zero = ~(|result);

    always_comb begin
        case (operation)
            OpAnd:
                result = inX & inY;
            OpOr:
                result = inX | inY;
            OpAdd:
                result = inX + inY;
            OpSub:
                result = inX - inY;
            OpSlt:
                result = (signedX < signedY) ? 32'h1 : 32'h0;
            OpSltU:
                result = (inX < inY) ? 32'h1 : 32'h0;
            OpXor:
                result = inX ^ inY;
            OpEqual:
                result = (inX == inY) ? 32'h1 : 32'h0;
            OpShiftLeft:
                result = inX << shamt;
            OpShiftRight:
                result = inX >> shamt;
            OpShiftRightA:
                result = word_t'(signedX >>> shamt); // Sign fill
            OpGreaterEqual:
                result = (signedX >= signedY) ? 32'h1 : 32'h0;
            OpGreaterEqualU:
                result = (inX >= inY) ? 32'h1 : 32'h0;
            default:
                result = inX; // Former NOR code lands here
        endcase
    end

endmodule

/* hw/AluDecode.sv */
`timescale 1ns/1ps

module AluDecode import ExecPkg::*; (
    input  logic         clk,
    input  logic         arstN,
    input  logic         inValid,
    input  word_t        instr,
    input  word_t        pc,
    input  word_t        rs1Value,
    input  word_t        rs2Value,
    output decodeStage_t decoded
);

    // Shared funct3 mapping of OP and OP-IMM
    function automatic aluOp_t arithOp(input logic [2:0] funct3, input logic alt);
        aluOp_t op;
        case (funct3)
            3'b000:  op = alt ? OpSub : OpAdd;
            3'b001:  op = OpShiftLeft;
            3'b010:  op = OpSlt;
            3'b011:  op = OpSltU;
            3'b100:  op = OpXor;
            3'b101:  op = alt ? OpShiftRightA : OpShiftRight;
            3'b110:  op = OpOr;
            default: op = OpAnd;
        endcase
        return op;
    endfunction

    logic [6:0]   opcode;
    logic [2:0]   funct3;
    word_t        immI;
    word_t        immB;
    word_t        immU;
    word_t        immJ;
    decodeStage_t decodedNext;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        decodedNext           = '0;
        decodedNext.valid     = inValid;
        decodedNext.operation = OpAdd;
        decodedNext.operandX  = rs1Value;
        decodedNext.operandY  = rs2Value;
        decodedNext.immediate = immI;
        decodedNext.pc        = pc;
        decodedNext.rd        = instr[11:7];
        case (opcode)
            OpcOp: begin
                decodedNext.operation = arithOp(funct3, instr[30]);
                decodedNext.writesRd  = 1'b1;
            end
            OpcOpImm: begin
                // Bit 30 is part of the immediate except for SRAI
                decodedNext.operation = arithOp(funct3, (funct3 == 3'b101) && instr[30]);
                decodedNext.operandY  = immI;
                decodedNext.writesRd  = 1'b1;
            end
            OpcBranch: begin
                decodedNext.immediate = immB;
                decodedNext.isBranch  = 1'b1;
                case (funct3)
                    3'b000:  decodedNext.operation = OpEqual;         // BEQ
                    3'b001:  decodedNext.operation = OpSub;           // BNE
                    3'b100:  decodedNext.operation = OpSlt;           // BLT
                    3'b101:  decodedNext.operation = OpGreaterEqual;  // BGE
                    3'b110:  decodedNext.operation = OpSltU;          // BLTU
                    3'b111:  decodedNext.operation = OpGreaterEqualU; // BGEU
                    default: decodedNext.isBranch  = 1'b0;            // Reserved funct3
                endcase
            end
            OpcLui: begin
                decodedNext.operandX  = '0; // 0 + U-immediate
                decodedNext.operandY  = immU;
                decodedNext.immediate = immU;
                decodedNext.writesRd  = 1'b1;
            end
            OpcJal: begin
                decodedNext.immediate = immJ;
                decodedNext.isJal     = 1'b1;
                decodedNext.writesRd  = 1'b1;
            end
            default: ; // Unsupported, valid passes with no effect
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decoded <= '0;
        end else begin
            decoded <= decodedNext;
        end
    end

endmodule

/* hw/AluStage.sv */
`timescale 1ns/1ps

module AluStage import ExecPkg::*; (
    input  logic         clk,
    input  logic         arstN,
    input  decodeStage_t decoded,
    output aluStage_t    executed
);

    word_t     aluResult;
    logic      aluZero;
    word_t     target;
    word_t     link;
    aluStage_t executedNext;

    Alu Alu_inst (
        .operation (decoded.operation),
        .inX       (decoded.operandX),
        .inY       (decoded.operandY),
        .result    (aluResult),
        .zero      (aluZero)
    );

    // Separate adders so branch compare and target run in parallel
    assign target = decoded.pc + decoded.immediate;
    assign link   = decoded.pc + 32'd4;

    always_comb begin
        executedNext.valid    = decoded.valid;
        executedNext.result   = aluResult;
        executedNext.zero     = aluZero;
        executedNext.target   = target;
        executedNext.link     = link;
        executedNext.rd       = decoded.rd;
        executedNext.isBranch = decoded.isBranch;
        executedNext.isJal    = decoded.isJal;
        executedNext.writesRd = decoded.writesRd;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            executed <= '0;
        end else begin
            executed <= executedNext;
        end
    end

endmodule

/* hw/BranchResolve.sv */
`timescale 1ns/1ps

module BranchResolve import ExecPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  aluStage_t executed,
    output logic      resValid,
    output word_t     result,
    output regAddr_t  rd,
    output logic      writeEnable,
    output logic      branchTaken,
    output word_t     target
);

    logic  takenNext;
    logic  writeNext;
    word_t resultNext;

    // Branch compare ops yield nonzero when taken
    assign takenNext = executed.valid &
                       ((executed.isBranch & ~executed.zero) | executed.isJal);

    // x0 is never written
    assign writeNext = executed.valid & executed.writesRd & (executed.rd != '0);

    assign resultNext = executed.isJal ? executed.link : executed.result;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resValid    <= 1'b0;
            result      <= '0;
            rd          <= '0;
            writeEnable <= 1'b0;
            branchTaken <= 1'b0;
            target      <= '0;
        end else begin
            resValid    <= executed.valid;
            result      <= resultNext;
            rd          <= executed.rd;
            writeEnable <= writeNext;
            branchTaken <= takenNext;
            target      <= executed.target;
        end
    end

endmodule

/* hw/ExecPkg.sv */
package ExecPkg;

    typedef logic [31:0] word_t;    // Data word, operand and address
    typedef logic [4:0]  regAddr_t; // Register index

    // ALU operation codes, NOR code left unassigned
    typedef enum logic [3:0] {
        OpAnd           = 4'b0000,
        OpOr            = 4'b0001,
        OpAdd           = 4'b0010,
        OpShiftRightA   = 4'b0011,
        OpSub           = 4'b0110,
        OpSlt           = 4'b0111,
        OpShiftLeft     = 4'b1000,
        OpShiftRight    = 4'b1001,
        OpXor           = 4'b1010,
        OpGreaterEqual  = 4'b1011,
        OpGreaterEqualU = 4'b1101,
        OpEqual         = 4'b1110,
        OpSltU          = 4'b1111
    } aluOp_t;

    localparam logic [6:0] OpcOp     = 7'b0110011; // Register-register
    localparam logic [6:0] OpcOpImm  = 7'b0010011; // Register-immediate
    localparam logic [6:0] OpcBranch = 7'b1100011;
    localparam logic [6:0] OpcLui    = 7'b0110111;
    localparam logic [6:0] OpcJal    = 7'b1101111;

    typedef struct packed {
        logic     valid;
        aluOp_t   operation;
        word_t    operandX;
        word_t    operandY;
        word_t    immediate; // B or J offset for branch and jump target
        word_t    pc;
        regAddr_t rd;
        logic     isBranch;
        logic     isJal;
        logic     writesRd;
    } decodeStage_t;

    typedef struct packed {
        logic     valid;
        word_t    result;
        logic     zero;
        word_t    target; // pc + offset
        word_t    link;   // pc + 4
        regAddr_t rd;
        logic     isBranch;
        logic     isJal;
        logic     writesRd;
    } aluStage_t;

endpackage

/* hw/ExecutePipe.sv */
`timescale 1ns/1ps

module ExecutePipe import ExecPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     inValid,
    input  word_t    instr,
    input  word_t    pc,
    input  word_t    rs1Value,
    input  word_t    rs2Value,
    output logic     resValid,
    output word_t    result,
    output regAddr_t rd,
    output logic     writeEnable,
    output logic     branchTaken,
    output word_t    target
);

    decodeStage_t decoded;  // Stage 1 to 2
    aluStage_t    executed; // Stage 2 to 3

    AluDecode AluDecode_inst (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .instr    (instr),
        .pc       (pc),
        .rs1Value (rs1Value),
        .rs2Value (rs2Value),
        .decoded  (decoded)
    );

    AluStage AluStage_inst (
        .clk      (clk),
        .arstN    (arstN),
        .decoded  (decoded),
        .executed (executed)
    );

    BranchResolve BranchResolve_inst (
        .clk         (clk),
        .arstN       (arstN),
        .executed    (executed),
        .resValid    (resValid),
        .result      (result),
        .rd          (rd),
        .writeEnable (writeEnable),
        .branchTaken (branchTaken),
        .target      (target)
    );

endmodule

/* tests/ExecutePipeTb.sv */
`timescale 1ns/1ps

module ExecutePipeTb import ExecPkg::*; ();

    localparam int ClkPeriod   = 20;
    localparam int IssueCount  = 10 * 5 + 6 * 4 + 3 * 3 + 6 * 3 + 6 + 64;
    localparam int SlackCycles = 100;   // Reset, idle cycles and drains

    localparam logic [3:0] RegOps [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3,
                                           4'h4, 4'h5, 4'hD, 4'h6, 4'h7}; // {funct7[5], funct3}
    localparam logic [2:0] ImmF3 [6]    = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
    localparam logic [2:0] BranchF3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    typedef struct packed {
        regAddr_t rd;
        logic     writeEnable;
        logic     branchTaken;
        logic     checkResult;
        logic     checkTarget;
        word_t    result;
        word_t    target;
    } expect_t;

    logic     clk;
    logic     arstN;
    logic     inValid;
    word_t    instr;
    word_t    pc;
    word_t    rs1Value;
    word_t    rs2Value;
    logic     resValid;
    word_t    result;
    regAddr_t rd;
    logic     writeEnable;
    logic     branchTaken;
    word_t    target;

    integer  seed = 32'h6758;
    int      cycle = 0;
    expect_t expQ[$];   // In issue order
    string   nameQ[$];
    int      dueQ[$];

    ExecutePipe ExecutePipe_inst (.*);

    bind ExecutePipe ExecutePipeAssertions ExecutePipeAssertions_inst (.*);

    function automatic word_t refAlu(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // RV32I semantics for the supported subset
    function automatic expect_t predict(input word_t ins, input word_t pcVal,
                                        input word_t a, input word_t b);
        expect_t    e;
        logic [2:0] f3;
        word_t      immI;
        f3   = ins[14:12];
        immI = {{20{ins[31]}}, ins[31:20]};
        e    = '0;
        e.rd = ins[11:7];
        case (ins[6:0])
            OpcOp: begin
                e.checkResult = 1'b1;
                e.writeEnable = e.rd != 0;
                e.result      = refAlu(f3, ins[30], a, b);
            end
            OpcOpImm: begin
                e.checkResult = 1'b1;
                e.writeEnable = e.rd != 0;
                e.result      = refAlu(f3, (f3 == 3'b101) && ins[30], a, immI);
            end
            OpcBranch: begin
                e.checkTarget = 1'b1;
                e.target = pcVal + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                case (f3)
                    3'b000:  e.branchTaken = a == b;
                    3'b001:  e.branchTaken = a != b;
                    3'b100:  e.branchTaken = $signed(a) < $signed(b);
                    3'b101:  e.branchTaken = $signed(a) >= $signed(b);
                    3'b110:  e.branchTaken = a < b;
                    3'b111:  e.branchTaken = a >= b;
                    default: e.branchTaken = 1'b0;
                endcase
            end
            OpcLui: begin
                e.checkResult = 1'b1;
                e.writeEnable = e.rd != 0;
                e.result      = {ins[31:12], 12'b0};
            end
            OpcJal: begin
                e.checkResult = 1'b1;
                e.checkTarget = 1'b1;
                e.writeEnable = e.rd != 0;
                e.branchTaken = 1'b1;
                e.result = pcVal + 32'd4;
                e.target = pcVal + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: ; // No effect expected
        endcase
        return e;
    endfunction

    function automatic word_t rType(input logic [3:0] op, input regAddr_t rdx);
        return {1'b0, op[3], 5'b0, 5'd2, 5'd1, op[2:0], rdx, OpcOp};
    endfunction

    function automatic word_t iType(input logic [2:0] f3, input logic [11:0] imm,
                                    input regAddr_t rdx);
        return {imm, 5'd1, f3, rdx, OpcOpImm};
    endfunction

    function automatic word_t bType(input logic [2:0] f3, input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], OpcBranch};
    endfunction

    function automatic word_t jType(input logic [20:0] off, input regAddr_t rdx);
        return {off[20], off[10:1], off[11], off[19:12], rdx, OpcJal};
    endfunction

    task automatic stopRun();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkValue(input string testName, input string field,
                              input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("mismatch in %s, %s: expected %h actual %h",
                     testName, field, expected, actual);
            stopRun();
        end
    endtask

    task automatic issue(input string name, input word_t ins, input word_t pcVal,
                         input word_t a, input word_t b);
        @(posedge clk);
        inValid  <= 1'b1;
        instr    <= ins;
        pc       <= pcVal;
        rs1Value <= a;
        rs2Value <= b;
        expQ.push_back(predict(ins, pcVal, a, b));
        nameQ.push_back(name);
        dueQ.push_back(cycle + 4); // Sampled next edge, then three stage registers
    endtask

    task automatic drain();
        @(posedge clk);
        inValid <= 1'b0;
        while (expQ.size() != 0)
            @(posedge clk);
    endtask

    always @(posedge clk) cycle <= cycle + 1;

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        expect_t want;
        string   name;
        int      due;
        if (arstN && resValid) begin
            if (expQ.size() == 0) begin
                $display("resValid pulsed with no instruction in flight");
                stopRun();
            end else begin
                want = expQ.pop_front();
                name = nameQ.pop_front();
                due  = dueQ.pop_front();
                checkValue(name, "latency", due, cycle);
                checkValue(name, "writeEnable", want.writeEnable, writeEnable);
                checkValue(name, "branchTaken", want.branchTaken, branchTaken);
                if (want.checkResult)
                    checkValue(name, "result", want.result, result);
                if (want.checkResult)
                    checkValue(name, "rd", want.rd, rd);
                if (want.checkTarget)
                    checkValue(name, "target", want.target, target);
            end
        end else begin
            checkValue("idle", "writeEnable", 0, writeEnable);
            checkValue("idle", "branchTaken", 0, branchTaken);
            if (dueQ.size() != 0 && dueQ[0] <= cycle) begin
                $display("result of %s did not appear three cycles after issue", nameQ[0]);
                stopRun();
            end
        end
    end

    task automatic resetIdle();
        repeat (5) begin
            @(negedge clk);
            checkValue("reset", "resValid", 0, resValid);
            checkValue("reset", "writeEnable", 0, writeEnable);
            checkValue("reset", "branchTaken", 0, branchTaken);
        end
    endtask

    task automatic regRegOps();
        word_t edgeX [3] = '{32'h8000_0000, 32'hFFFF_FFF0, 32'h7FFF_FFFF};
        word_t edgeY [3] = '{32'h0000_0001, 32'h0000_0023, 32'hFFFF_FFFF}; // 35 shifts by 3
        for (int i = 0; i < 10; i++) begin
            for (int k = 0; k < 3; k++)
                issue("regReg", rType(RegOps[i], 5'd3), 32'h100, edgeX[k], edgeY[k]);
            repeat (2)
                issue("regReg", rType(RegOps[i], 5'd4), 32'h100, $random(seed), $random(seed));
        end
        drain();
    endtask

    task automatic regImmOps();
        logic [11:0] imms [4]   = '{12'hFFF, 12'h800, 12'h7FF, 12'h0A5};
        logic [4:0]  shamts [3] = '{5'd0, 5'd5, 5'd31};
        for (int i = 0; i < 6; i++)
            for (int k = 0; k < 4; k++)
                issue("regImm", iType(ImmF3[i], imms[k], 5'd5), 32'h200, $random(seed), 0);
        for (int s = 0; s < 3; s++) begin
            issue("regImm", iType(3'd1, {7'h00, shamts[s]}, 5'd6), 32'h200, 32'h8765_4321, 0);
            issue("regImm", iType(3'd5, {7'h00, shamts[s]}, 5'd6), 32'h200, 32'h8765_4321, 0);
            issue("regImm", iType(3'd5, {7'h20, shamts[s]}, 5'd6), 32'h200, 32'h8765_4321, 0);
        end
        drain();
    endtask

    task automatic branchCases();
        word_t lhs [3] = '{32'd5, 32'hFFFF_FFFD, 32'd4};
        word_t rhs [3] = '{32'd5, 32'd4, 32'hFFFF_FFFD};
        for (int i = 0; i < 6; i++)
            for (int k = 0; k < 3; k++)
                issue("branch", bType(BranchF3[i], (k == 1) ? 13'h1FF0 : 13'h0804),
                      32'h0000_2000 + 32'(i * 16), lhs[k], rhs[k]);
        drain();
    endtask

    task automatic luiJalX0();
        issue("luiJal", {20'hABCDE, 5'd7, OpcLui}, 32'h300, 0, 0);
        issue("luiJal", {20'h80001, 5'd0, OpcLui}, 32'h304, 0, 0);
        issue("luiJal", jType(21'h1FF800, 5'd1), 32'h0000_4000, 0, 0); // Backward jump
        issue("luiJal", jType(21'h000100, 5'd0), 32'h0000_4004, 0, 0);
        issue("luiJal", rType(4'h0, 5'd0), 32'h308, 32'd9, 32'd1);
        issue("luiJal", {25'h1ABCDEF, 7'b0000011}, 32'h30C, 32'd1, 32'd2); // Load opcode
        drain();
    endtask

    task automatic mixedStream();
        word_t r;
        word_t ins;
        int    kind;
        for (int n = 0; n < 64; n++) begin
            kind = {$random(seed)} % 5;
            r    = $random(seed);
            case (kind)
                0:       ins = rType(RegOps[r[31:28] % 10], r[11:7]);
                1:       ins = iType(ImmF3[r[31:29] % 6], r[27:16], r[11:7]);
                2:       ins = bType(BranchF3[r[31:29] % 6], r[12:0]);
                3:       ins = {r[31:12], r[11:7], OpcLui};
                default: ins = jType(r[20:0], r[11:7]);
            endcase
            issue("stream", ins, $random(seed) & 32'hFFFF_FFFC, $random(seed), $random(seed));
        end
        drain();
    endtask

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        arstN    = 1'b0;
        inValid  = 1'b0;
        instr    = '0;
        pc       = '0;
        rs1Value = '0;
        rs2Value = '0;
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
        resetIdle();
        regRegOps();
        regImmOps();
        branchCases();
        luiJalX0();
        mixedStream();
        if (ExecutePipe_inst.ExecutePipeAssertions_inst.failCount == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("pipeline timing assertions failed during the run");
            stopRun();
        end
    end

    initial begin
        #((IssueCount + SlackCycles) * ClkPeriod);
        $display("timeout: the pipeline did not deliver all results in time");
        stopRun();
    end

endmodule

/* tests/ExecutePipe_assertions.sv */
`timescale 1ns/1ps

module ExecutePipeAssertions import ExecPkg::*; (
    input logic     clk,
    input logic     arstN,
    input logic     inValid,
    input logic     resValid,
    input logic     writeEnable,
    input logic     branchTaken,
    input regAddr_t rd
);

    int failCount = 0;

    // One register per stage, so valid trails by three edges
    assert property (@(posedge clk) disable iff (!arstN) resValid == $past(inValid, 3))
        else begin
            failCount++;
            $error("resValid does not follow inValid by three cycles");
        end

    assert property (@(posedge clk) disable iff (!arstN) branchTaken |-> resValid)
        else begin
            failCount++;
            $error("branchTaken high without resValid");
        end

    assert property (@(posedge clk) disable iff (!arstN)
                     writeEnable |-> (resValid && (rd != '0)))
        else begin
            failCount++;
            $error("writeEnable high without resValid or with rd x0");
        end

endmodule
